/* src/vid_pkg.sv */
package vid_pkg;

    localparam int APB_AW = 8;
    localparam int APB_DW = 32;
    localparam int COORD_W = 13;
    localparam int PDIV_W = 6;
    localparam int COLOR_W = 8;
    localparam int PIXEL_W = 3 * COLOR_W;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    typedef logic [APB_AW-1:0] apb_addr_t;
    typedef logic [APB_DW-1:0] apb_data_t;
    typedef logic [COORD_W-1:0] coord_t;     // Position or count on a line or frame
    typedef logic [PDIV_W-1:0] pdiv_t;       // Pixel period minus one, in clocks
    typedef logic [PIXEL_W-1:0] pixel_t;     // {R, G, B}
    typedef logic [COLOR_W-1:0] color_t;
    typedef logic [FIFO_AW:0] fifo_ptr_t;    // Extra wrap bit

    localparam apb_addr_t CTRL_ADDR = 8'h00;
    localparam apb_addr_t H1_ADDR = 8'h28;
    localparam apb_addr_t H2_ADDR = 8'h30;
    localparam apb_addr_t V1_ADDR = 8'h38;
    localparam apb_addr_t V2_ADDR = 8'h40;
    localparam apb_addr_t PIXEL_ADDR = 8'h58;   // Write only
    localparam apb_addr_t STATUS_ADDR = 8'h60;  // Write clears sticky flags

    localparam int CTRL_EN_BIT = 3;
    localparam int CTRL_PDIV_LSB = 4;
    localparam int FIELD_HI_LSB = 13;           // Upper field of H1/H2/V1/V2

    // Region of the current pixel within a line
    typedef enum logic [1:0] {
        active,
        front_porch,
        sync,
        back_porch
    } h_state_t;

endpackage

/* src/vid_regs.sv */
`timescale 1ns/1ns

module vid_regs (
    input  logic               clk,
    input  logic               reset_n,

    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  vid_pkg::apb_addr_t paddr,
    input  vid_pkg::apb_data_t pwdata,
    output vid_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,

    output logic               en,
    output vid_pkg::pdiv_t     pdiv,
    output vid_pkg::coord_t    hend,
    output vid_pkg::coord_t    hsize,
    output vid_pkg::coord_t    hsync_start,
    output vid_pkg::coord_t    hsync_end,
    output vid_pkg::coord_t    vend,
    output vid_pkg::coord_t    vsize,
    output vid_pkg::coord_t    vsync_start,
    output vid_pkg::coord_t    vsync_end,

    output logic               push,
    output vid_pkg::pixel_t    push_data,
    output logic               clear_flags,

    input  logic               empty,
    input  logic               full,
    input  logic               overflow,
    input  logic               underflow
);

    logic access;
    logic wr_en;
    logic addr_ok;

    assign access = psel && penable;             // Access cycle
    assign wr_en = access && pwrite;
    assign pready = 1'b1;                        // No wait states
    assign pslverr = access && !addr_ok;

    assign push = wr_en && (paddr == vid_pkg::PIXEL_ADDR);
    assign push_data = pwdata[vid_pkg::PIXEL_W-1:0];
    assign clear_flags = wr_en && (paddr == vid_pkg::STATUS_ADDR);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en <= 1'b0;
            pdiv <= '0;
            hend <= '0;
            hsize <= '0;
            hsync_start <= '0;
            hsync_end <= '0;
            vend <= '0;
            vsize <= '0;
            vsync_start <= '0;
            vsync_end <= '0;
        end else if (wr_en) begin
            case (paddr)
                vid_pkg::CTRL_ADDR: begin
                    en <= pwdata[vid_pkg::CTRL_EN_BIT];
                    pdiv <= pwdata[vid_pkg::CTRL_PDIV_LSB +: vid_pkg::PDIV_W];
                end
                vid_pkg::H1_ADDR: begin
                    hend <= pwdata[0 +: vid_pkg::COORD_W];
                    hsize <= pwdata[vid_pkg::FIELD_HI_LSB +: vid_pkg::COORD_W];
                end
                vid_pkg::H2_ADDR: begin
                    hsync_end <= pwdata[0 +: vid_pkg::COORD_W];
                    hsync_start <= pwdata[vid_pkg::FIELD_HI_LSB +: vid_pkg::COORD_W];
                end
                vid_pkg::V1_ADDR: begin
                    vend <= pwdata[0 +: vid_pkg::COORD_W];
                    vsize <= pwdata[vid_pkg::FIELD_HI_LSB +: vid_pkg::COORD_W];
                end
                vid_pkg::V2_ADDR: begin
                    vsync_end <= pwdata[0 +: vid_pkg::COORD_W];
                    vsync_start <= pwdata[vid_pkg::FIELD_HI_LSB +: vid_pkg::COORD_W];
                end
                default: ;                       // PIXEL and STATUS act as pulses
            endcase
        end
    end

    // Read data and address check
    always_comb begin
        prdata = '0;
        addr_ok = 1'b1;
        case (paddr)
            vid_pkg::CTRL_ADDR: begin
                prdata[vid_pkg::CTRL_EN_BIT] = en;
                prdata[vid_pkg::CTRL_PDIV_LSB +: vid_pkg::PDIV_W] = pdiv;
            end
            vid_pkg::H1_ADDR: begin
                prdata[0 +: vid_pkg::COORD_W] = hend;
                prdata[vid_pkg::FIELD_HI_LSB +: vid_pkg::COORD_W] = hsize;
            end
            vid_pkg::H2_ADDR: begin
                prdata[0 +: vid_pkg::COORD_W] = hsync_end;
                prdata[vid_pkg::FIELD_HI_LSB +: vid_pkg::COORD_W] = hsync_start;
            end
            vid_pkg::V1_ADDR: begin
                prdata[0 +: vid_pkg::COORD_W] = vend;
                prdata[vid_pkg::FIELD_HI_LSB +: vid_pkg::COORD_W] = vsize;
            end
            vid_pkg::V2_ADDR: begin
                prdata[0 +: vid_pkg::COORD_W] = vsync_end;
                prdata[vid_pkg::FIELD_HI_LSB +: vid_pkg::COORD_W] = vsync_start;
            end
            vid_pkg::PIXEL_ADDR: addr_ok = pwrite;       // Reads are refused
            vid_pkg::STATUS_ADDR: prdata[3:0] = {underflow, overflow, full, empty};
            default: addr_ok = 1'b0;
        endcase
    end

endmodule

/* src/vid_timing.sv */
`timescale 1ns/1ns

module vid_timing (
    input  logic            clk,
    input  logic            reset_n,

    input  logic            en,
    input  vid_pkg::pdiv_t  pdiv,
    input  vid_pkg::coord_t hend,
    input  vid_pkg::coord_t hsize,
    input  vid_pkg::coord_t hsync_start,
    input  vid_pkg::coord_t hsync_end,
    input  vid_pkg::coord_t vend,
    input  vid_pkg::coord_t vsize,
    input  vid_pkg::coord_t vsync_start,
    input  vid_pkg::coord_t vsync_end,

    output logic            hsync,
    output logic            hblank,
    output logic            vsync,
    output logic            vblank,
    output logic            pixel_active
);

    vid_pkg::pdiv_t   div_cnt;
    vid_pkg::coord_t  hcnt;
    vid_pkg::coord_t  vcnt;
    vid_pkg::coord_t  h_next;
    vid_pkg::coord_t  v_next;
    vid_pkg::h_state_t h_state;
    logic             expire;
    logic             line_end;
    logic             v_act;

    // Line region that a horizontal position falls into
    function automatic vid_pkg::h_state_t region(input vid_pkg::coord_t pos);
        if (pos < hsize)
            return vid_pkg::active;
        else if (pos < hsync_start)
            return vid_pkg::front_porch;
        else if (pos < hsync_end)
            return vid_pkg::sync;
        else
            return vid_pkg::back_porch;
    endfunction

    assign expire = en && (div_cnt >= pdiv);     // Last clock of this position
    assign line_end = (hcnt == hend);
    assign h_next = line_end ? '0 : hcnt + 1'b1;
    assign v_next = (vcnt == vend) ? '0 : vcnt + 1'b1;
    assign v_act = (vcnt < vsize);

    assign pixel_active = expire && (h_state == vid_pkg::active) && v_act;

    // Divider, position counters and line FSM
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
            hcnt <= '0;
            vcnt <= '0;
            h_state <= vid_pkg::active;
        end else if (!en) begin
            div_cnt <= '0;
            hcnt <= '0;
            vcnt <= '0;
            h_state <= region('0);               // Track programmed hsize
        end else if (expire) begin
            div_cnt <= '0;
            hcnt <= h_next;
            h_state <= region(h_next);
            if (line_end) begin
                vcnt <= v_next;                  // Next line
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Sync and blank for the position that is ending
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hsync <= 1'b0;
            hblank <= 1'b1;
            vsync <= 1'b0;
            vblank <= 1'b1;
        end else if (!en) begin
            hsync <= 1'b0;
            hblank <= 1'b1;
            vsync <= 1'b0;
            vblank <= 1'b1;
        end else if (expire) begin
            hsync <= (h_state == vid_pkg::sync);
            hblank <= (h_state != vid_pkg::active);
            vsync <= (vcnt >= vsync_start) && (vcnt < vsync_end);
            vblank <= !v_act;
        end
    end

endmodule

/* src/vid_pixel_fifo.sv */
`timescale 1ns/1ns

module vid_pixel_fifo (
    input  logic            clk,
    input  logic            reset_n,

    input  logic            push,
    input  vid_pkg::pixel_t push_data,
    input  logic            pop,
    input  logic            clear_flags,

    output vid_pkg::pixel_t head,
    output logic            empty,
    output logic            full,
    output logic            overflow,
    output logic            underflow
);

    vid_pkg::pixel_t    mem [vid_pkg::FIFO_DEPTH];
    vid_pkg::fifo_ptr_t wr_ptr;
    vid_pkg::fifo_ptr_t rd_ptr;
    logic               do_push;
    logic               do_pop;

    // Wrap bits tell full from empty at the same address
    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[vid_pkg::FIFO_AW] != rd_ptr[vid_pkg::FIFO_AW]) &&
                  (wr_ptr[vid_pkg::FIFO_AW-1:0] == rd_ptr[vid_pkg::FIFO_AW-1:0]);

    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    assign head = mem[rd_ptr[vid_pkg::FIFO_AW-1:0]];  // Fall-through head

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[vid_pkg::FIFO_AW-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Sticky error flags where a new refusal wins over a clear
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            overflow <= 1'b0;
            underflow <= 1'b0;
        end else begin
            overflow <= (overflow && !clear_flags) || (push && full);
            underflow <= (underflow && !clear_flags) || (pop && empty);
        end
    end

endmodule

/* src/vid_pixel_out.sv */
`timescale 1ns/1ns

module vid_pixel_out (
    input  logic            clk,
    input  logic            reset_n,

    input  logic            pixel_active,
    input  vid_pkg::pixel_t head,
    input  logic            empty,

    output logic            pop,
    output vid_pkg::color_t r,
    output vid_pkg::color_t g,
    output vid_pkg::color_t b
);

    assign pop = pixel_active;                   // FIFO ignores it when empty

    // Channels carry a pixel for one clock per strobe, lined up with the
    // sync and blank edge of the same position
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r <= '0;
            g <= '0;
            b <= '0;
        end else if (pixel_active && !empty) begin
            {r, g, b} <= head;
        end else begin
            r <= '0;                             // Blanking or underrun
            g <= '0;
            b <= '0;
        end
    end

endmodule

/* src/vid_top.sv */
`timescale 1ns/1ns

module vid_top (
    input  logic               clk,
    input  logic               reset_n,

    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  vid_pkg::apb_addr_t paddr,
    input  vid_pkg::apb_data_t pwdata,
    output vid_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,

    output logic               hsync,
    output logic               hblank,
    output logic               vsync,
    output logic               vblank,
    output vid_pkg::color_t    r,
    output vid_pkg::color_t    g,
    output vid_pkg::color_t    b
);

    logic            en;
    vid_pkg::pdiv_t  pdiv;
    vid_pkg::coord_t hend;
    vid_pkg::coord_t hsize;
    vid_pkg::coord_t hsync_start;
    vid_pkg::coord_t hsync_end;
    vid_pkg::coord_t vend;
    vid_pkg::coord_t vsize;
    vid_pkg::coord_t vsync_start;
    vid_pkg::coord_t vsync_end;

    logic            push;
    vid_pkg::pixel_t push_data;
    logic            clear_flags;
    logic            pop;
    vid_pkg::pixel_t head;
    logic            empty;
    logic            full;
    logic            overflow;
    logic            underflow;
    logic            pixel_active;

    vid_regs i_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .en          (en),
        .pdiv        (pdiv),
        .hend        (hend),
        .hsize       (hsize),
        .hsync_start (hsync_start),
        .hsync_end   (hsync_end),
        .vend        (vend),
        .vsize       (vsize),
        .vsync_start (vsync_start),
        .vsync_end   (vsync_end),
        .push        (push),
        .push_data   (push_data),
        .clear_flags (clear_flags),
        .empty       (empty),
        .full        (full),
        .overflow    (overflow),
        .underflow   (underflow)
    );

    vid_timing i_timing (
        .clk          (clk),
        .reset_n      (reset_n),
        .en           (en),
        .pdiv         (pdiv),
        .hend         (hend),
        .hsize        (hsize),
        .hsync_start  (hsync_start),
        .hsync_end    (hsync_end),
        .vend         (vend),
        .vsize        (vsize),
        .vsync_start  (vsync_start),
        .vsync_end    (vsync_end),
        .hsync        (hsync),
        .hblank       (hblank),
        .vsync        (vsync),
        .vblank       (vblank),
        .pixel_active (pixel_active)
    );

    vid_pixel_fifo i_fifo (
        .clk         (clk),
        .reset_n     (reset_n),
        .push        (push),
        .push_data   (push_data),
        .pop         (pop),
        .clear_flags (clear_flags),
        .head        (head),
        .empty       (empty),
        .full        (full),
        .overflow    (overflow),
        .underflow   (underflow)
    );

    vid_pixel_out i_out (
        .clk          (clk),
        .reset_n      (reset_n),
        .pixel_active (pixel_active),
        .head         (head),
        .empty        (empty),
        .pop          (pop),
        .r            (r),
        .g            (g),
        .b            (b)
    );

endmodule

/* sim/tb_vid_top.sv */
`timescale 1ns/1ns

module tb_vid_top;

    localparam int HEND = 11;
    localparam int HSIZE = 8;
    localparam int HS_START = 9;
    localparam int HS_END = 11;
    localparam int VEND = 5;
    localparam int VSIZE = 4;
    localparam int VS_START = 4;
    localparam int VS_END = 5;
    localparam int PDIV = 1;
    localparam int N_PIXELS = 12;

    localparam int LINE_CLKS = (HEND + 1) * (PDIV + 1);
    localparam int FRAME_CLKS = (VEND + 1) * LINE_CLKS;
    localparam int FRAMES_USED = 12;
    localparam int MAX_CYCLES = FRAMES_USED * FRAME_CLKS + 1000;   // Plus APB traffic

    localparam logic [31:0] CTRL_STOP = 32'(PDIV) << vid_pkg::CTRL_PDIV_LSB;
    localparam logic [31:0] CTRL_RUN = CTRL_STOP | (32'h1 << vid_pkg::CTRL_EN_BIT);
    localparam logic [31:0] CTRL_MASK = 32'h0000_03F8;     // en and divider
    localparam logic [31:0] FIELD_MASK = 32'h03FF_FFFF;    // Two 13-bit fields
    localparam logic [31:0] STAT_EMPTY = 32'h1;
    localparam logic [31:0] STAT_FULL = 32'h2;
    localparam logic [31:0] STAT_OVF = 32'h4;
    localparam logic [31:0] STAT_UNF = 32'h8;
    localparam logic [1:0] SEL_HSYNC = 2'd0;
    localparam logic [1:0] SEL_HBLANK = 2'd1;
    localparam logic [1:0] SEL_VSYNC = 2'd2;
    localparam logic [1:0] SEL_VBLANK = 2'd3;

    logic clk;
    logic reset_n;
    logic psel;
    logic penable;
    logic pwrite;
    vid_pkg::apb_addr_t paddr;
    vid_pkg::apb_data_t pwdata;
    vid_pkg::apb_data_t prdata;
    logic pready;
    logic pslverr;
    logic hsync;
    logic hblank;
    logic vsync;
    logic vblank;
    vid_pkg::color_t r;
    vid_pkg::color_t g;
    vid_pkg::color_t b;

    logic [3:0] mon;
    int cycle = 0;
    int seed;
    int tests = 0;
    int checks = 0;
    int errors = 0;
    int prop_errors = 0;
    bit en_shadow = 1'b0;                  // Last en value written
    vid_pkg::pixel_t expect_q[$];

    vid_top i_dut (.*);

    assign mon = {vblank, vsync, hblank, hsync};

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        while (cycle < MAX_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    pready_high: assert property (@(posedge clk) disable iff (!reset_n) pready)
        else begin
            prop_errors++;
            $display("[ERROR] %0t ns: pready is low", $time);
        end

    // Blanked positions carry no color
    blank_rgb_zero: assert property (@(posedge clk) disable iff (!reset_n)
        (hblank || vblank) |-> ({r, g, b} == 24'h0))
        else begin
            prop_errors++;
            $display("[ERROR] %0t ns: RGB 0x%06h during blanking", $time, {r, g, b});
        end

    idle_outputs: assert property (@(posedge clk) disable iff (!reset_n)
        !en_shadow |=> (hblank && vblank && !hsync && !vsync && ({r, g, b} == 24'h0)))
        else begin
            prop_errors++;
            $display("[ERROR] %0t ns: outputs not at reset values while disabled", $time);
        end

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        value_ok: assert (got == exp) else begin
            errors++;
            $display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic apply_reset();
        reset_n = 1'b0;
        en_shadow = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    endtask

    task automatic apb_write(input vid_pkg::apb_addr_t addr, input logic [31:0] data);
        @(negedge clk);
        psel = 1'b1;                       // Setup cycle
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;                    // Access cycle
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input vid_pkg::apb_addr_t addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        data = prdata;                     // Still in the access phase
        err = pslverr;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_enable(input bit on);
        apb_write(vid_pkg::CTRL_ADDR, on ? CTRL_RUN : CTRL_STOP);
        en_shadow = on;
    endtask

    task automatic read_expect(input string what, input vid_pkg::apb_addr_t addr,
                               input logic [31:0] exp);
        logic [31:0] data;
        logic err;
        apb_read(addr, data, err);
        check_eq(what, data, exp);
        check_eq({what, " pslverr"}, {31'h0, err}, 32'h0);
    endtask

    task automatic field_roundtrip(input string what, input vid_pkg::apb_addr_t addr,
                                   input logic [31:0] mask, input logic [31:0] value);
        apb_write(addr, value);
        read_expect(what, addr, value & mask);
    endtask

    task automatic push_random(input bit keep);
        logic [31:0] rnd;
        rnd = $random(seed);
        apb_write(vid_pkg::PIXEL_ADDR, {8'h0, rnd[23:0]});
        if (keep)
            expect_q.push_back(rnd[23:0]);
    endtask

    // Clocks from a rising edge of the selected output to its fall and next rise
    task automatic measure_pulse(input logic [1:0] sel, output int period, output int high);
        int t_rise;
        int t_fall;
        while (mon[sel]) @(negedge clk);
        while (!mon[sel]) @(negedge clk);
        t_rise = cycle;
        while (mon[sel]) @(negedge clk);
        t_fall = cycle;
        while (!mon[sel]) @(negedge clk);
        period = cycle - t_rise;
        high = t_fall - t_rise;
    endtask

    // Each active position shows the next queued pixel on its first clock and zero after it
    task automatic check_stream(input int n_clks);
        int act_clk;
        bit synced;
        vid_pkg::pixel_t exp;
        vid_pkg::h_state_t st;
        act_clk = 0;
        synced = 1'b0;
        repeat (n_clks) begin
            @(negedge clk);
            if (hblank) begin
                act_clk = 0;
                synced = 1'b1;
            end else if (synced && !vblank) begin
                exp = '0;
                if ((act_clk % (PDIV + 1)) == 0 && expect_q.size() > 0)
                    exp = expect_q.pop_front();
                st = i_dut.i_timing.h_state;
                checks++;
                pixel_ok: assert ({r, g, b} == exp) else begin
                    errors++;
                    $display("[ERROR] %0t ns: RGB 0x%06h, expected 0x%06h, line FSM in %s",
                             $time, {r, g, b}, exp, st.name());
                end
                act_clk++;
            end
        end
    endtask

    task automatic check_idle(input string when);
        check_eq({"sync/blank ", when}, {28'h0, hsync, hblank, vsync, vblank}, 32'h5);
        check_eq({"RGB ", when}, {8'h0, r, g, b}, 32'h0);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("Test %0d %s: %0d error(s)", tests, name, errors + prop_errors - err_before);
    endtask

    initial begin
        int start;
        int period;
        int high;
        logic [31:0] data;
        logic err;

        seed = 32'h15bf_67d4;
        reset_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        apply_reset();

        start = errors + prop_errors;
        field_roundtrip("CTRL", vid_pkg::CTRL_ADDR, CTRL_MASK, $random(seed) & ~32'h8);
        field_roundtrip("H1", vid_pkg::H1_ADDR, FIELD_MASK, $random(seed));
        field_roundtrip("H2", vid_pkg::H2_ADDR, FIELD_MASK, $random(seed));
        field_roundtrip("V1", vid_pkg::V1_ADDR, FIELD_MASK, $random(seed));
        field_roundtrip("V2", vid_pkg::V2_ADDR, FIELD_MASK, $random(seed));
        read_expect("STATUS", vid_pkg::STATUS_ADDR, STAT_EMPTY);
        apb_read(8'h04, data, err);
        check_eq("unmapped read pslverr", {31'h0, err}, 32'h1);
        apb_read(vid_pkg::PIXEL_ADDR, data, err);
        check_eq("PIXEL read pslverr", {31'h0, err}, 32'h1);
        finish_test("register readback", start);

        start = errors + prop_errors;
        apb_write(vid_pkg::H1_ADDR, (32'(HSIZE) << vid_pkg::FIELD_HI_LSB) | 32'(HEND));
        apb_write(vid_pkg::H2_ADDR, (32'(HS_START) << vid_pkg::FIELD_HI_LSB) | 32'(HS_END));
        apb_write(vid_pkg::V1_ADDR, (32'(VSIZE) << vid_pkg::FIELD_HI_LSB) | 32'(VEND));
        apb_write(vid_pkg::V2_ADDR, (32'(VS_START) << vid_pkg::FIELD_HI_LSB) | 32'(VS_END));
        set_enable(1'b1);
        measure_pulse(SEL_HSYNC, period, high);
        check_eq("hsync period", period, LINE_CLKS);
        check_eq("hsync width", high, (HS_END - HS_START) * (PDIV + 1));
        measure_pulse(SEL_HBLANK, period, high);
        check_eq("hblank period", period, LINE_CLKS);
        check_eq("hblank low width", period - high, HSIZE * (PDIV + 1));
        finish_test("horizontal timing", start);

        start = errors + prop_errors;
        measure_pulse(SEL_VSYNC, period, high);
        check_eq("vsync period", period, FRAME_CLKS);
        check_eq("vsync width", high, (VS_END - VS_START) * LINE_CLKS);
        measure_pulse(SEL_VBLANK, period, high);
        check_eq("vblank period", period, FRAME_CLKS);
        check_eq("vblank low width", period - high, VSIZE * LINE_CLKS);
        finish_test("vertical timing", start);

        start = errors + prop_errors;
        set_enable(1'b0);
        apb_write(vid_pkg::STATUS_ADDR, 32'h0);       // Underflow from the timing runs
        repeat (N_PIXELS) push_random(1'b1);
        set_enable(1'b1);
        check_stream(FRAME_CLKS + LINE_CLKS);
        check_eq("pixels not shown", expect_q.size(), 0);
        finish_test("pixel stream", start);

        start = errors + prop_errors;
        set_enable(1'b0);
        apb_write(vid_pkg::STATUS_ADDR, 32'h0);
        repeat (vid_pkg::FIFO_DEPTH) push_random(1'b1);
        push_random(1'b0);                             // Dropped as the FIFO is full
        read_expect("STATUS after overfill", vid_pkg::STATUS_ADDR, STAT_FULL | STAT_OVF);
        apb_write(vid_pkg::STATUS_ADDR, 32'h0);
        read_expect("STATUS after clear", vid_pkg::STATUS_ADDR, STAT_FULL);
        set_enable(1'b1);
        check_stream(FRAME_CLKS);
        check_eq("pixels not shown", expect_q.size(), 0);
        check_stream(FRAME_CLKS);                      // Empty FIFO shows all zero
        read_expect("STATUS after underrun", vid_pkg::STATUS_ADDR, STAT_EMPTY | STAT_UNF);
        finish_test("overflow and underflow", start);

        start = errors + prop_errors;
        set_enable(1'b0);
        repeat (LINE_CLKS) @(negedge clk);
        check_idle("after disable");
        set_enable(1'b1);
        repeat (LINE_CLKS) @(negedge clk);
        apply_reset();
        check_idle("after reset");
        read_expect("CTRL after reset", vid_pkg::CTRL_ADDR, 32'h0);
        repeat (LINE_CLKS) @(negedge clk);
        finish_test("reset and disable", start);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors + prop_errors);
        if (errors + prop_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* filelist.f */
src/vid_pkg.sv
src/vid_regs.sv
src/vid_timing.sv
src/vid_pixel_fifo.sv
src/vid_pixel_out.sv
src/vid_top.sv
sim/tb_vid_top.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_vid_top
FILELIST := filelist.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
